// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = gemac_client_adapter_tb
FLIST    = flist.f
LOG      = sim.log
PASS_MSG = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: common/gemac_pkg.sv
// Shared types and constants for the GEMAC client adapter.
// Host words use the 36-bit framing: occ, eof and sof on top, then 32 data bits
// with byte 0 in the top byte.
// A word with both sof and eof set that is not the first word of its frame ends
// an errored frame. Frames must therefore span two words, which means 5 bytes or more.
// STAGE_DEPTH must be a power of two of at least 2.
package gemac_pkg;

   // Entries in each pipeline stage register
   localparam int STAGE_DEPTH = 2;
   localparam int STAGE_PTR_W = $clog2(STAGE_DEPTH);
   localparam int STAGE_CNT_W = $clog2(STAGE_DEPTH + 1);

   // Occupancy code of a last word with all four bytes valid
   localparam logic [1:0] OCC_FULL = 2'd0;

   // Host side word, field order matches the 36-bit bus layout
   typedef struct packed {
      logic [1:0]  occ;
      logic        eof;
      logic        sof;
      logic [31:0] data;
   } f36_word_t;

   // Link-layer byte, error only counts together with eof
   typedef struct packed {
      logic       error;
      logic       eof;
      logic       sof;
      logic [7:0] data;
   } ll8_t;

endpackage

// File: flist.f
common/gemac_pkg.sv
logic/stage_reg.sv
tx/fifo36_to_ll8.sv
tx/ll8_to_txmac.sv
rx/rxmac_to_ll8.sv
rx/ll8_to_fifo36.sv
logic/gemac_client_adapter.sv
test/gemac_client_adapter_asserts.sv
test/gemac_client_adapter_tb.sv

// File: logic/gemac_client_adapter.sv
// Client framing adapter between 36-bit host words and a GEMAC byte interface.
// Everything runs on clk_i. There is no clock crossing and no pause handling.
// Transmit: host words, byte split, stage, then the MAC transmit port.
// Receive: MAC receive port, stage, word packing, stage, then host words.
// Frames must be 5 bytes or longer.
`timescale 1ns/1ps

module gemac_client_adapter
   import gemac_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,
   // Host transmit words
   input  f36_word_t  tx_f36_data_i,
   input  logic       tx_f36_src_rdy_i,
   output logic       tx_f36_dst_rdy_o,
   // MAC transmit port
   output logic [7:0] mac_tx_data_o,
   output logic       mac_tx_valid_o,
   output logic       mac_tx_error_o,
   input  logic       mac_tx_ack_i,
   // MAC receive port
   input  logic [7:0] mac_rx_data_i,
   input  logic       mac_rx_valid_i,
   input  logic       mac_rx_ack_i,
   input  logic       mac_rx_error_i,
   // Host receive words
   output f36_word_t  rx_f36_data_o,
   output logic       rx_f36_src_rdy_o,
   input  logic       rx_f36_dst_rdy_i
);

   ll8_t      tx_ll;
   logic      tx_ll_src_rdy, tx_ll_dst_rdy;
   ll8_t      tx_ls;
   logic      tx_ls_src_rdy, tx_ls_dst_rdy;
   ll8_t      rx_ll;
   logic      rx_ll_src_rdy, rx_ll_dst_rdy;
   ll8_t      rx_ls;
   logic      rx_ls_src_rdy, rx_ls_dst_rdy;
   f36_word_t rx_f36;
   logic      rx_f36_src_rdy, rx_f36_dst_rdy;

   // Transmit chain
   fifo36_to_ll8 tx_split (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .f36_i(tx_f36_data_i), .f36_src_rdy_i(tx_f36_src_rdy_i), .f36_dst_rdy_o(tx_f36_dst_rdy_o),
      .ll_o(tx_ll), .ll_src_rdy_o(tx_ll_src_rdy), .ll_dst_rdy_i(tx_ll_dst_rdy));

   stage_reg #(.payload_t(ll8_t)) tx_stage (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .data_i(tx_ll), .src_rdy_i(tx_ll_src_rdy), .dst_rdy_o(tx_ll_dst_rdy),
      .data_o(tx_ls), .src_rdy_o(tx_ls_src_rdy), .dst_rdy_i(tx_ls_dst_rdy));

   ll8_to_txmac tx_mac_if (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .ll_i(tx_ls), .ll_src_rdy_i(tx_ls_src_rdy), .ll_dst_rdy_o(tx_ls_dst_rdy),
      .mac_tx_data_o(mac_tx_data_o), .mac_tx_valid_o(mac_tx_valid_o),
      .mac_tx_error_o(mac_tx_error_o), .mac_tx_ack_i(mac_tx_ack_i));

   // Receive chain
   rxmac_to_ll8 rx_mac_if (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .mac_rx_data_i(mac_rx_data_i), .mac_rx_valid_i(mac_rx_valid_i),
      .mac_rx_ack_i(mac_rx_ack_i), .mac_rx_error_i(mac_rx_error_i),
      .ll_o(rx_ll), .ll_src_rdy_o(rx_ll_src_rdy), .ll_dst_rdy_i(rx_ll_dst_rdy));

   stage_reg #(.payload_t(ll8_t)) rx_stage (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .data_i(rx_ll), .src_rdy_i(rx_ll_src_rdy), .dst_rdy_o(rx_ll_dst_rdy),
      .data_o(rx_ls), .src_rdy_o(rx_ls_src_rdy), .dst_rdy_i(rx_ls_dst_rdy));

   ll8_to_fifo36 rx_pack (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .ll_i(rx_ls), .ll_src_rdy_i(rx_ls_src_rdy), .ll_dst_rdy_o(rx_ls_dst_rdy),
      .f36_o(rx_f36), .f36_src_rdy_o(rx_f36_src_rdy), .f36_dst_rdy_i(rx_f36_dst_rdy));

   stage_reg #(.payload_t(f36_word_t)) rx_out_stage (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .data_i(rx_f36), .src_rdy_i(rx_f36_src_rdy), .dst_rdy_o(rx_f36_dst_rdy),
      .data_o(rx_f36_data_o), .src_rdy_o(rx_f36_src_rdy_o), .dst_rdy_i(rx_f36_dst_rdy_i));

endmodule

// File: logic/stage_reg.sv
// Small register FIFO placed between pipeline stages.
// Output is valid one cycle after an input transfer, one transfer per cycle.
// dst_rdy_o comes straight from a flop, so ready paths do not chain along a pipeline.
// Depth comes from STAGE_DEPTH, which must be a power of two so the pointers wrap.
`timescale 1ns/1ps

module stage_reg
   import gemac_pkg::*;
#(
   parameter type payload_t = logic
) (
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  payload_t data_i,
   input  logic     src_rdy_i,
   output logic     dst_rdy_o,
   output payload_t data_o,
   output logic     src_rdy_o,
   input  logic     dst_rdy_i
);

   payload_t               mem_q [STAGE_DEPTH];
   logic [STAGE_PTR_W-1:0] wr_ptr_q;
   logic [STAGE_PTR_W-1:0] rd_ptr_q;
   logic [STAGE_CNT_W-1:0] count_q;
   logic [STAGE_CNT_W-1:0] count_d;
   logic                   full_q;
   logic                   push;
   logic                   pop;

   assign dst_rdy_o = !full_q;
   assign src_rdy_o = (count_q != '0);
   assign data_o    = mem_q[rd_ptr_q];
   assign push      = src_rdy_i && !full_q;
   assign pop       = src_rdy_o && dst_rdy_i;

   always_comb begin
      count_d = count_q;
      if (push && !pop) begin
         count_d = count_q + STAGE_CNT_W'(1);
      end else if (pop && !push) begin
         count_d = count_q - STAGE_CNT_W'(1);
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         full_q   <= 1'b0;
      end else begin
         if (push) wr_ptr_q <= wr_ptr_q + STAGE_PTR_W'(1);
         if (pop) rd_ptr_q <= rd_ptr_q + STAGE_PTR_W'(1);
         count_q <= count_d;
         // Ready for the next cycle is decided here, never from dst_rdy_i directly
         full_q  <= (count_d == STAGE_CNT_W'(STAGE_DEPTH));
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_ptr_q] <= data_i;
      end
   end

endmodule

// File: rx/ll8_to_fifo36.sv
// Packs link-layer bytes into 36-bit host words, byte 0 in the top byte.
// A word goes out the cycle after its fourth byte or after its eof byte.
// occ gives the valid bytes of the last word, OCC_FULL when all four are used.
// An eof with error also sets sof on the last word, which marks the frame bad.
// This only reads as an error when the frame spans two words or more.
`timescale 1ns/1ps

module ll8_to_fifo36
   import gemac_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  ll8_t      ll_i,
   input  logic      ll_src_rdy_i,
   output logic      ll_dst_rdy_o,
   output f36_word_t f36_o,
   output logic      f36_src_rdy_o,
   input  logic      f36_dst_rdy_i
);

   f36_word_t  word_q;
   logic       word_valid_q;
   logic [1:0] cnt_q;
   logic       ll_xfer;
   logic       f36_xfer;
   logic       word_done;

   // The word register doubles as the output, a finished word frees it the same cycle
   assign ll_dst_rdy_o  = !word_valid_q || f36_dst_rdy_i;
   assign ll_xfer       = ll_src_rdy_i && ll_dst_rdy_o;
   assign f36_xfer      = word_valid_q && f36_dst_rdy_i;
   assign word_done     = ll_i.eof || (cnt_q == 2'd3);
   assign f36_o         = word_q;
   assign f36_src_rdy_o = word_valid_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         word_valid_q <= 1'b0;
         cnt_q        <= 2'd0;
      end else begin
         if (f36_xfer) word_valid_q <= 1'b0;
         if (ll_xfer) begin
            if (word_done) begin
               word_valid_q <= 1'b1;
               cnt_q        <= 2'd0;
            end else begin
               cnt_q <= cnt_q + 2'd1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (ll_xfer) begin
         if (cnt_q == 2'd0) begin
            word_q.data <= {ll_i.data, 24'h000000};
            word_q.sof  <= ll_i.sof;
         end else begin
            word_q.data[31 - 8*cnt_q -: 8] <= ll_i.data;
         end
         if (ll_i.eof && ll_i.error) begin
            word_q.sof <= 1'b1;
         end
         word_q.eof <= ll_i.eof;
         // A count of four wraps to zero, which is OCC_FULL
         word_q.occ <= ll_i.eof ? cnt_q + 2'd1 : OCC_FULL;
      end
   end

endmodule

// File: rx/rxmac_to_ll8.sv
// Turns MAC receive bytes into a link-layer byte stream.
// A byte is offered once its successor arrives or the frame end is known, so the
// last byte waits for the MAC ack or error before it goes out with eof.
// The MAC cannot be stalled. A byte that arrives while the held byte is still
// unaccepted causes an overrun. The held byte then becomes an eof with error and
// the rest of the frame is dropped. A frame that overruns on its first byte is
// dropped whole.
`timescale 1ns/1ps

module rxmac_to_ll8
   import gemac_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic [7:0] mac_rx_data_i,
   input  logic       mac_rx_valid_i,
   input  logic       mac_rx_ack_i,
   input  logic       mac_rx_error_i,
   output ll8_t       ll_o,
   output logic       ll_src_rdy_o,
   input  logic       ll_dst_rdy_i
);

   ll8_t byte_q;
   logic full_q;
   logic first_q;
   logic drop_q;
   logic pop;
   logic frame_end;

   assign frame_end    = mac_rx_ack_i || mac_rx_error_i;
   assign ll_o         = byte_q;
   assign ll_src_rdy_o = full_q && (byte_q.eof || mac_rx_valid_i);
   assign pop          = ll_src_rdy_o && ll_dst_rdy_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         byte_q  <= '0;
         full_q  <= 1'b0;
         first_q <= 1'b1;
         drop_q  <= 1'b0;
      end else begin
         if (pop) full_q <= 1'b0;
         if (mac_rx_valid_i && !drop_q) begin
            if (full_q && !pop) begin
               // Overrun, close the frame on the held byte unless it already ends one
               drop_q <= 1'b1;
               if (!byte_q.eof) begin
                  byte_q.eof   <= 1'b1;
                  byte_q.error <= 1'b1;
               end
            end else begin
               byte_q  <= '{error: 1'b0, eof: 1'b0, sof: first_q, data: mac_rx_data_i};
               full_q  <= 1'b1;
               first_q <= 1'b0;
            end
         end
         if (frame_end) begin
            first_q <= 1'b1;
            drop_q  <= 1'b0;
            if (!drop_q && full_q && !byte_q.eof) begin
               byte_q.eof   <= 1'b1;
               byte_q.error <= mac_rx_error_i;
            end
         end
      end
   end

endmodule

// File: test/gemac_client_adapter_asserts.sv
// Protocol assertions for the GEMAC client adapter, bound to the top level.
// The start-of-frame hold rule tracks the ack locally.
`timescale 1ns/1ps

module gemac_client_adapter_asserts
   import gemac_pkg::*;
(
   input logic       clk_i,
   input logic       arst_n_i,
   input logic [7:0] mac_tx_data_o,
   input logic       mac_tx_valid_o,
   input logic       mac_tx_error_o,
   input logic       mac_tx_ack_i,
   input f36_word_t  rx_f36_data_o,
   input logic       rx_f36_src_rdy_o,
   input logic       rx_f36_dst_rdy_i
);

   logic acked_q;
   int   fail_count = 0;

   // Set once the MAC has taken the first byte of the current frame
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         acked_q <= 1'b0;
      end else if (!mac_tx_valid_o) begin
         acked_q <= 1'b0;
      end else if (mac_tx_ack_i) begin
         acked_q <= 1'b1;
      end
   end

   tx_first_byte_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mac_tx_valid_o && !acked_q && !mac_tx_ack_i |=> $stable(mac_tx_data_o))
      else begin
         fail_count++;
         $error("transmit byte changed before the start ack");
      end

   rx_word_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rx_f36_src_rdy_o && !rx_f36_dst_rdy_i |=> rx_f36_src_rdy_o && $stable(rx_f36_data_o))
      else begin
         fail_count++;
         $error("receive word dropped or changed under back-pressure");
      end

   idle_in_reset: assert property (@(posedge clk_i)
      !arst_n_i |-> !mac_tx_valid_o && !mac_tx_error_o && !rx_f36_src_rdy_o)
      else begin
         fail_count++;
         $error("valid output high during reset");
      end

   tx_error_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mac_tx_error_o |=> !mac_tx_error_o)
      else begin
         fail_count++;
         $error("transmit error longer than one cycle");
      end

endmodule

bind gemac_client_adapter gemac_client_adapter_asserts asserts0 (.*);

// File: test/gemac_client_adapter_tb.sv
// Testbench for the GEMAC client adapter.
// A loopback MAC model acks each transmit frame and replays it on the receive port.
// Expected host words are built from the sent bytes, checks are immediate assertions.
// Frames are 5 to 64 bytes long, all stimulus comes from one LFSR.
`timescale 1ns/1ps

module gemac_client_adapter_tb
   import gemac_pkg::*;
();

   localparam int NUM_FRAMES      = 25;
   localparam int WATCHDOG_CYCLES = NUM_FRAMES * 70 * 10 + 1000;
   localparam int KIND_GOOD       = 0;
   localparam int KIND_RXERR      = 1;
   localparam int KIND_UNDERRUN   = 2;
   localparam int KIND_OVERRUN    = 3;

   logic       clk_i;
   logic       arst_n_i;
   f36_word_t  tx_f36_data_i;
   logic       tx_f36_src_rdy_i;
   logic       tx_f36_dst_rdy_o;
   logic [7:0] mac_tx_data_o;
   logic       mac_tx_valid_o;
   logic       mac_tx_error_o;
   logic       mac_tx_ack_i;
   logic [7:0] mac_rx_data_i;
   logic       mac_rx_valid_i;
   logic       mac_rx_ack_i;
   logic       mac_rx_error_i;
   f36_word_t  rx_f36_data_o;
   logic       rx_f36_src_rdy_o;
   logic       rx_f36_dst_rdy_i;

   logic [31:0] lfsr_q = 32'hc2d30771;
   int          errors = 0;
   int          checks = 0;
   int          pending = 0;
   int          underruns = 0;
   int          word_idx = 0;
   int          cur_kind = KIND_GOOD;
   logic        rx_hold = 1'b0;
   string       test_name = "reset";
   f36_word_t   exp_q[$];
   int          rx_kind_q[$];
   logic        mac_err_q[$];
   int          ack_delay_q[$];

   gemac_client_adapter dut0 (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = !clk_i;
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      end
      return r;
   endfunction

   task automatic send_frame(input int len, input int kind, input int gap_word);
      logic [7:0]  bytes[$];
      logic [31:0] tmp;
      f36_word_t   w;
      f36_word_t   e;
      int          nwords;
      for (int i = 0; i < len; i++) begin
         tmp = rand_bits(8);
         bytes.push_back(tmp[7:0]);
      end
      nwords = (len + 3) / 4;
      mac_err_q.push_back(kind == KIND_RXERR);
      // Ack delay of the MAC model for this frame
      ack_delay_q.push_back(int'(rand_bits(3)));
      pending++;
      if (kind != KIND_UNDERRUN) rx_kind_q.push_back(kind);
      for (int wi = 0; wi < nwords; wi++) begin
         w = '0;
         for (int b = 0; b < 4; b++) begin
            if (wi * 4 + b < len) w.data[31 - 8*b -: 8] = bytes[wi * 4 + b];
         end
         w.sof = (wi == 0);
         w.eof = (wi == nwords - 1);
         w.occ = w.eof ? 2'(len % 4) : OCC_FULL;
         e = w;
         // Error frames end in a word with sof set as well
         if (kind == KIND_RXERR && w.eof) e.sof = 1'b1;
         if (kind == KIND_GOOD || kind == KIND_RXERR) exp_q.push_back(e);
         if (wi == gap_word) begin
            tx_f36_src_rdy_i = 1'b0;
            repeat (40) @(negedge clk_i);
         end
         tx_f36_data_i    = w;
         tx_f36_src_rdy_i = 1'b1;
         while (!tx_f36_dst_rdy_o) @(negedge clk_i);
         @(negedge clk_i);
      end
      tx_f36_src_rdy_i = 1'b0;
   endtask

   task automatic replay_frame(input logic [7:0] frame[$], input logic with_error);
      foreach (frame[i]) begin
         mac_rx_data_i  = frame[i];
         mac_rx_valid_i = 1'b1;
         @(negedge clk_i);
      end
      mac_rx_valid_i = 1'b0;
      mac_rx_ack_i   = !with_error;
      mac_rx_error_i = with_error;
      @(negedge clk_i);
      mac_rx_ack_i   = 1'b0;
      mac_rx_error_i = 1'b0;
   endtask

   // MAC transmit side, random ack delay, then loopback
   initial begin : tx_mac_model
      logic [7:0] frame[$];
      int         delay;
      logic       err_replay;
      forever begin
         @(negedge clk_i);
         if (mac_tx_valid_o) begin
            frame = {};
            delay = ack_delay_q.pop_front();
            repeat (delay) @(negedge clk_i);
            mac_tx_ack_i = 1'b1;
            frame.push_back(mac_tx_data_o);
            @(negedge clk_i);
            mac_tx_ack_i = 1'b0;
            while (mac_tx_valid_o) begin
               frame.push_back(mac_tx_data_o);
               @(negedge clk_i);
            end
            err_replay = mac_err_q.pop_front();
            if (mac_tx_error_o) begin
               underruns++;
               pending--;
            end else begin
               replay_frame(frame, err_replay);
            end
         end
      end
   end

   task automatic check_word(input f36_word_t got);
      f36_word_t e;
      if (word_idx == 0) begin
         if (rx_kind_q.size() == 0) begin
            errors++;
            $display("%s: a host word arrived with no frame expected", test_name);
            return;
         end
         cur_kind = rx_kind_q.pop_front();
      end
      if (cur_kind == KIND_OVERRUN) begin
         if (got.eof) begin
            checks++;
            assert (got.sof && word_idx > 0) else begin
               errors++;
               $display("%s: overrun frame did not end in an error word", test_name);
            end
         end
      end else begin
         e = exp_q.pop_front();
         checks++;
         assert (got == e) else begin
            errors++;
            $display("Mismatch %s: expected %h actual %h", test_name, e, got);
         end
      end
      if (got.eof) begin
         word_idx = 0;
         pending--;
      end else begin
         word_idx++;
      end
   endtask

   // Host receive side, ready is set before the transfer is judged
   initial begin : rx_monitor
      forever begin
         @(negedge clk_i);
         rx_f36_dst_rdy_i = !rx_hold;
         if (rx_f36_src_rdy_o && rx_f36_dst_rdy_i) check_word(rx_f36_data_o);
      end
   end

   task automatic drain();
      wait (pending == 0);
      repeat (5) @(negedge clk_i);
   endtask

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("Timeout: frames still outstanding after %0d cycles", WATCHDOG_CYCLES);
      $display("Finished with errors");
      $finish;
   end

   initial begin : main
      int base;
      arst_n_i         = 1'b0;
      tx_f36_data_i    = '0;
      tx_f36_src_rdy_i = 1'b0;
      mac_tx_ack_i     = 1'b0;
      mac_rx_data_i    = 8'h00;
      mac_rx_valid_i   = 1'b0;
      mac_rx_ack_i     = 1'b0;
      mac_rx_error_i   = 1'b0;
      rx_f36_dst_rdy_i = 1'b1;
      repeat (10) @(negedge clk_i);
      arst_n_i = 1'b1;
      @(negedge clk_i);
      checks++;
      assert (tx_f36_dst_rdy_o && !mac_tx_valid_o && !mac_tx_error_o && !rx_f36_src_rdy_o)
      else begin
         errors++;
         $display("%s: outputs not in their idle state after reset", test_name);
      end

      test_name = "loopback";
      repeat (20) send_frame(5 + int'(rand_bits(6)) % 60, KIND_GOOD, -1);
      drain();

      test_name = "underrun";
      base = underruns;
      send_frame(32, KIND_UNDERRUN, 2);
      send_frame(20, KIND_GOOD, -1);
      drain();
      checks++;
      assert (underruns == base + 1) else begin
         errors++;
         $display("Mismatch %s: expected %0d actual %0d", test_name, 1, underruns - base);
      end

      test_name = "rx_error";
      send_frame(40, KIND_RXERR, -1);
      drain();

      test_name = "overrun";
      rx_hold = 1'b1;
      fork
         send_frame(64, KIND_OVERRUN, -1);
         begin
            wait (mac_rx_valid_i);
            repeat (50) @(negedge clk_i);
            rx_hold = 1'b0;
         end
      join
      send_frame(24, KIND_GOOD, -1);
      drain();

      // Protocol assertions bound into the DUT add their failures here
      errors += dut0.asserts0.fail_count;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: tx/fifo36_to_ll8.sv
// Splits 36-bit host words into link-layer bytes, top byte first.
// On an eof word only the bytes given by occ are sent, the last one carrying eof.
// The next word is taken as the last byte leaves, so bytes flow without bubbles.
// Transmit bytes never carry the error flag.
`timescale 1ns/1ps

module fifo36_to_ll8
   import gemac_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  f36_word_t f36_i,
   input  logic      f36_src_rdy_i,
   output logic      f36_dst_rdy_o,
   output ll8_t      ll_o,
   output logic      ll_src_rdy_o,
   input  logic      ll_dst_rdy_i
);

   f36_word_t   word_q;
   logic        word_valid_q;
   logic [1:0]  byte_q;
   logic [1:0]  last_byte;
   logic        last;
   logic        word_take;
   logic        byte_take;
   logic [31:0] shifted;

   // Index of the final byte, occ of 1 to 3 means that many from the top
   assign last_byte = (word_q.eof && (word_q.occ != OCC_FULL)) ? word_q.occ - 2'd1 : 2'd3;
   assign last      = (byte_q == last_byte);

   assign byte_take     = word_valid_q && ll_dst_rdy_i;
   assign f36_dst_rdy_o = !word_valid_q || (last && ll_dst_rdy_i);
   assign word_take     = f36_src_rdy_i && f36_dst_rdy_o;

   // Current byte moved to the top of the word
   assign shifted = word_q.data << {byte_q, 3'b000};

   assign ll_src_rdy_o = word_valid_q;
   assign ll_o = '{error: 1'b0,
                   eof:   word_q.eof && last,
                   sof:   word_q.sof && (byte_q == 2'd0),
                   data:  shifted[31:24]};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         word_valid_q <= 1'b0;
         byte_q       <= 2'd0;
      end else if (word_take) begin
         word_valid_q <= 1'b1;
         byte_q       <= 2'd0;
      end else if (byte_take) begin
         if (last) begin
            word_valid_q <= 1'b0;
         end
         byte_q <= byte_q + 2'd1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (word_take) begin
         word_q <= f36_i;
      end
   end

endmodule

// File: tx/ll8_to_txmac.sv
// Drives the MAC transmit port from link-layer bytes.
// The first byte is held with valid high until the MAC pulses ack, after which
// one byte is consumed on every cycle.
// If the link layer runs dry after the ack, tx error pulses for one cycle and
// the rest of the frame is discarded up to its eof.
// Bytes arriving outside a frame without sof are thrown away.
`timescale 1ns/1ps

module ll8_to_txmac
   import gemac_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  ll8_t       ll_i,
   input  logic       ll_src_rdy_i,
   output logic       ll_dst_rdy_o,
   output logic [7:0] mac_tx_data_o,
   output logic       mac_tx_valid_o,
   output logic       mac_tx_error_o,
   input  logic       mac_tx_ack_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT_ACK,
      ST_SEND,
      ST_DROP
   } state_t;

   state_t state_q;
   state_t state_d;

   assign mac_tx_data_o = ll_i.data;

   always_comb begin
      state_d        = state_q;
      mac_tx_valid_o = 1'b0;
      mac_tx_error_o = 1'b0;
      ll_dst_rdy_o   = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (ll_src_rdy_i) begin
               if (ll_i.sof) begin
                  state_d = ST_WAIT_ACK;
               end else begin
                  ll_dst_rdy_o = 1'b1;
               end
            end
         end
         ST_WAIT_ACK: begin
            // Byte stays put until the MAC takes it with the ack
            mac_tx_valid_o = 1'b1;
            ll_dst_rdy_o   = mac_tx_ack_i;
            if (mac_tx_ack_i) begin
               state_d = ll_i.eof ? ST_IDLE : ST_SEND;
            end
         end
         ST_SEND: begin
            if (ll_src_rdy_i) begin
               mac_tx_valid_o = 1'b1;
               ll_dst_rdy_o   = 1'b1;
               if (ll_i.eof) state_d = ST_IDLE;
            end else begin
               mac_tx_error_o = 1'b1;   // underrun
               state_d        = ST_DROP;
            end
         end
         default: begin
            ll_dst_rdy_o = 1'b1;
            if (ll_src_rdy_i && ll_i.eof) begin
               state_d = ST_IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

endmodule
